// ==== src.f ====
+incdir+design
+incdir+bench
design/page_cmd_pkg.sv
design/bus_op_pkg.sv
design/attr_port_if.sv
design/fill_counter.sv
design/fill_sequencer.sv
design/page_map.sv
design/page_attr.sv
design/page_unit_top.sv
bench/page_unit_tb.sv

// ==== bench/page_unit_table.svh ====
// Rows use seeded random map entries; include inside the bench module after map_entry is declared
`ifndef PAGE_UNIT_TABLE_SVH
`define PAGE_UNIT_TABLE_SVH

localparam int MAX_ROWS   = 64;                 // Bound on rows in one run
localparam int FILL_START = 1000;               // Page index where the fill begins

// Mask bits from the top: reprio, access, page index, map data, physad
typedef struct packed {
    page_cmd_pkg::page_cmd_e cmd;               // Command driven
    logic [31:0]             data;              // Data word
    bus_op_pkg::arb_op_e     op;                // Bus opcode
    logic                    besm6;             // BESM-6 mode level
    logic                    no_paging;         // Paging blocked level
    logic [4:0]              mask;              // Which outputs to compare
    logic [19:0]             physad;            // Expected physical address
    logic [19:0]             map;               // Expected map entry
    logic [9:0]              pg;                // Expected page index
    logic [2:0]              access;            // Expected dirty, used, zero
    logic                    reprio;            // Expected reprioritize bit
} row_t;

row_t rows [$];                                 // Rows waiting to be applied

function automatic void add_row(input page_cmd_pkg::page_cmd_e cmd, input logic [31:0] data,
        input bus_op_pkg::arb_op_e op, input logic besm6, input logic np, input logic [4:0] mask,
        input logic [19:0] physad, input logic [19:0] map, input logic [9:0] pg,
        input logic [2:0] access, input logic reprio);
    rows.push_back({cmd, data, op, besm6, np, mask, physad, map, pg, access, reprio});
endfunction

// Page index from data bits 19:10
function automatic void index_row(input int page, input logic [4:0] mask, input logic reprio);
    add_row(page_cmd_pkg::CMD_WRITE_PHYSPG, {12'd0, 10'(page), 10'd0}, bus_op_pkg::OP_NONE,
            1'b0, 1'b0, mask, '0, '0, 10'(page), 3'b000, reprio);
endfunction

function automatic void reprio_row(input logic value);
    add_row(page_cmd_pkg::CMD_WRITE_REPRIO, {31'd0, value}, bus_op_pkg::OP_NONE,
            1'b0, 1'b0, 5'b10000, '0, '0, '0, 3'b000, value);
endfunction

function automatic void access_row(input logic [2:0] bits, input logic [9:0] page);
    add_row(page_cmd_pkg::CMD_WRITE_ACCESS, {29'd0, bits}, bus_op_pkg::OP_NONE,
            1'b0, 1'b0, 5'b01100, '0, '0, page, bits, 1'b0);    // Bit 2 dirty, bit 1 used
endfunction

// Vaddr load with a random offset; normal mode, BESM-6 and no-paging follow the same rule
function automatic void translate_row(input int page, input logic besm6, input logic np);
    logic [31:0] va;
    logic [9:0]  vpage;
    logic [9:0]  top;
    va = $urandom();
    va[19:10] = 10'(page);
    vpage = besm6 ? {5'd0, va[14:10]} : va[19:10];      // Five page bits in BESM-6 mode
    top = np ? vpage : map_entry[vpage][19:10];         // Identity without paging
    add_row(page_cmd_pkg::CMD_LOAD_VADDR, va, bus_op_pkg::OP_NONE, besm6, np, 5'b00011,
            {top, va[9:0]}, map_entry[page], '0, 3'b000, 1'b0);
endfunction

// Fresh random map entry, written through a vaddr that points at the page
function automatic void map_write_rows(input int page);
    logic [31:0] va;
    va = $urandom();
    va[19:10] = 10'(page);
    map_entry[page] = 20'($urandom());
    add_row(page_cmd_pkg::CMD_LOAD_VADDR, va, bus_op_pkg::OP_NONE,
            1'b0, 1'b0, 5'b00000, '0, '0, '0, 3'b000, 1'b0);
    add_row(page_cmd_pkg::CMD_WRITE_MAP, {12'($urandom()), map_entry[page]}, bus_op_pkg::OP_NONE,
            1'b0, 1'b0, 5'b00011, {map_entry[page][19:10], va[9:0]}, map_entry[page],
            '0, 3'b000, 1'b0);
endfunction

// Clear the translated page, then request it; used always set, dirty as given
function automatic void bus_request_rows(input int page, input bus_op_pkg::arb_op_e op,
        input logic dirty);
    logic [31:0] va;
    logic [9:0]  tpage;
    va = $urandom();
    va[19:10] = 10'(page);
    tpage = map_entry[page][19:10];
    index_row(int'(tpage), 5'b00100, 1'b0);
    access_row(3'b000, tpage);
    add_row(page_cmd_pkg::CMD_LOAD_VADDR, va, bus_op_pkg::OP_NONE,
            1'b0, 1'b0, 5'b00000, '0, '0, '0, 3'b000, 1'b0);
    add_row(page_cmd_pkg::CMD_BUS_REQUEST, 32'($urandom()), op, 1'b0, 1'b0, 5'b01101,
            {tpage, va[9:0]}, '0, tpage, {dirty, 2'b10}, 1'b0);
endfunction

`endif

// ==== bench/page_unit_tb.sv ====
// Bench for page_unit_top; stops at the first mismatch, seed 80153, reprio memory unknown at start
`timescale 1ns/1ns
`default_nettype none

`include "page_unit_settings.svh"

module page_unit_tb;

    logic                    clk;
    logic                    reset;
    page_cmd_pkg::page_cmd_e i_cmd;
    logic [`PU_VADDR_W-1:0]  i_data;
    bus_op_pkg::arb_op_e     i_bus_op;
    logic                    i_no_paging;
    logic                    i_mode_besm6;
    logic [`PU_PHYS_W-1:0]   o_physad;
    logic [`PU_MAP_W-1:0]    o_map_data;
    logic [`PU_PAGE_W-1:0]   o_pg_index;
    logic [2:0]              o_access;
    logic                    o_reprio;
    logic                    o_fill_busy;
    logic                    o_changed;
    logic [`PU_MAP_W-1:0]    map_entry [`PU_PAGES];     // Entries the bench has written
    int                      cycles = 0;                // Clock edges so far
    int                      busy_cycles;               // Samples with the fill busy
    int                      page;

    `include "page_unit_table.svh"

    localparam int CYCLE_LIMIT = 16 + MAX_ROWS + `PU_PAGES + 200;  // Reset, rows, fill, margin

    page_unit_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                         // 20 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish");
            $display("*** TEST FAILED ***");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_row(input row_t r);
        if (r.mask[0]) check("o_physad", 32'(o_physad), 32'(r.physad));
        if (r.mask[1]) check("o_map_data", 32'(o_map_data), 32'(r.map));
        if (r.mask[2]) check("o_pg_index", 32'(o_pg_index), 32'(r.pg));
        if (r.mask[3]) check("o_access", 32'(o_access), 32'(r.access));
        if (r.mask[4]) check("o_reprio", 32'(o_reprio), 32'(r.reprio));
    endtask

    // ------------------------------
    // Row i goes out 2 ns after an edge, row i-1 is checked just before
    task automatic apply_rows();
        int i;
        for (i = 0; i <= rows.size(); i++) begin
            @(posedge clk);
            #2;
            if (i > 0) check_row(rows[i-1]);
            if (i < rows.size()) begin
                i_cmd        = rows[i].cmd;
                i_data       = rows[i].data;
                i_bus_op     = rows[i].op;
                i_mode_besm6 = rows[i].besm6;
                i_no_paging  = rows[i].no_paging;
            end else begin
                i_cmd = page_cmd_pkg::CMD_NOP;          // Table done
            end
        end
        rows.delete();
    endtask

    initial begin
        void'($urandom(80153));
        reset        = 1'b1;
        i_cmd        = page_cmd_pkg::CMD_NOP;
        i_data       = '0;
        i_bus_op     = bus_op_pkg::OP_NONE;
        i_no_paging  = 1'b0;
        i_mode_besm6 = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        check("o_fill_busy", 32'(o_fill_busy), 32'd0);
        check("o_changed", 32'(o_changed), 32'd0);
        check("o_pg_index", 32'(o_pg_index), 32'd0);
        map_write_rows(37);
        apply_rows();
        check("o_changed", 32'(o_changed), 32'd1);     // Set by the first map write

        // ------------------------------
        map_write_rows(700);
        map_write_rows(5);
        map_write_rows(677);                            // Low five page bits give page 5
        translate_row(700, 1'b0, 1'b0);
        translate_row(677, 1'b1, 1'b0);
        translate_row(37, 1'b0, 1'b1);
        translate_row(677, 1'b1, 1'b1);
        index_row(321, 5'b00100, 1'b0);
        access_row(3'b100, 10'd321);
        access_row(3'b010, 10'd321);
        reprio_row(1'b1);
        reprio_row(1'b0);
        bus_request_rows(700, bus_op_pkg::DRD, 1'b0);
        bus_request_rows(37, bus_op_pkg::DWR, 1'b1);
        for (page = FILL_START - 1; page <= FILL_START; page++) begin
            index_row(page, 5'b00100, 1'b0);
            reprio_row(1'b0);                           // Known zero before the fill
        end
        apply_rows();

        // ------------------------------
        @(posedge clk);
        #2;
        i_cmd = page_cmd_pkg::CMD_START_FILL;
        busy_cycles = 0;
        @(posedge clk);
        #2;
        while (o_fill_busy === 1'b1) begin
            busy_cycles++;
            i_data = '0;
            if (busy_cycles == 3) begin
                i_cmd = page_cmd_pkg::CMD_WRITE_REPRIO; // Must lose against the fill
            end else begin
                i_cmd = page_cmd_pkg::CMD_NOP;
            end
            @(posedge clk);
            #2;
        end
        i_cmd = page_cmd_pkg::CMD_NOP;
        check("o_fill_busy cycles", 32'(busy_cycles), 32'(`PU_PAGES - FILL_START));
        for (page = FILL_START - 1; page < `PU_PAGES; page++) begin
            index_row(page, 5'b10100, page >= FILL_START);
        end
        apply_rows();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/page_unit_top.sv ====
// Commands are plain strobes sampled every clock; outputs follow the registers one cycle later
`timescale 1ns/1ns
`default_nettype none

`include "page_unit_settings.svh"

module page_unit_top (
    input  wire                     clk,            // Clock
    input  wire                     reset,          // Synchronous reset
    input  page_cmd_pkg::page_cmd_e i_cmd,          // Command this cycle
    input  wire  [`PU_VADDR_W-1:0]  i_data,         // Data word
    input  bus_op_pkg::arb_op_e     i_bus_op,       // Bus request opcode
    input  wire                     i_no_paging,    // Paging blocked
    input  wire                     i_mode_besm6,   // BESM-6 mode
    output logic [`PU_PHYS_W-1:0]   o_physad,       // Physical address
    output logic [`PU_MAP_W-1:0]    o_map_data,     // Map entry at vaddr page
    output logic [`PU_PAGE_W-1:0]   o_pg_index,     // Physical page register
    output logic [2:0]              o_access,       // Dirty, used, zero
    output logic                    o_reprio,       // Reprioritize bit
    output logic                    o_fill_busy,    // Fill running
    output logic                    o_changed       // Tables changed
);

    logic                  fill_load;               // Counter load
    logic                  fill_step;               // Counter step
    logic [`PU_PAGE_W-1:0] fill_count;              // Counter value
    logic                  fill_last;               // Counter at last page

    attr_port_if u_port ();

    // ------------------------------
    // Translation and index
    // ------------------------------
    page_map u_map (
        .clk          (clk),
        .reset        (reset),
        .i_cmd        (i_cmd),
        .i_data       (i_data),
        .i_bus_op     (i_bus_op),
        .i_no_paging  (i_no_paging),
        .i_mode_besm6 (i_mode_besm6),
        .o_physad     (o_physad),
        .o_map_data   (o_map_data),
        .port         (u_port.map_mp)
    );

    page_attr u_attr (
        .clk       (clk),
        .reset     (reset),
        .i_cmd     (i_cmd),
        .i_data    (i_data),
        .port      (u_port.attr_mp),
        .o_access  (o_access),
        .o_reprio  (o_reprio),
        .o_changed (o_changed)
    );

    // ------------------------------
    // Reprioritize fill
    // ------------------------------
    fill_sequencer u_seq (
        .clk           (clk),
        .reset         (reset),
        .i_cmd         (i_cmd),
        .i_start_index (u_port.pg_index),
        .i_count       (fill_count),
        .i_count_last  (fill_last),
        .o_load        (fill_load),
        .o_step        (fill_step),
        .port          (u_port.fill_mp),
        .o_fill_busy   (o_fill_busy)
    );

    fill_counter u_cnt (
        .clk     (clk),
        .reset   (reset),
        .i_load  (fill_load),
        .i_start (u_port.pg_index),     // Fill begins at the current page
        .i_step  (fill_step),
        .o_count (fill_count),
        .o_last  (fill_last)
    );

    assign o_pg_index = u_port.pg_index;

endmodule

`default_nettype wire

// ==== design/page_attr.sv ====
// Attribute memories power up unknown; software or a fill must write them before they are read
`timescale 1ns/1ns
`default_nettype none

`include "page_unit_settings.svh"

module page_attr (
    input  wire                     clk,        // Clock
    input  wire                     reset,      // Synchronous reset
    input  page_cmd_pkg::page_cmd_e i_cmd,      // Command this cycle
    input  wire  [`PU_VADDR_W-1:0]  i_data,     // Data word
    attr_port_if.attr_mp            port,       // Map and fill strobes
    output logic [2:0]              o_access,   // Dirty, used, zero
    output logic                    o_reprio,   // Reprioritize bit of current page
    output logic                    o_changed   // Sticky change flag
);

    logic used_mem   [`PU_PAGES];               // Page referenced
    logic dirty_mem  [`PU_PAGES];               // Page modified
    logic reprio_mem [`PU_PAGES];               // Reprioritize request
    logic access_wr;                            // Software access write
    logic reprio_wr;                            // Software reprio write
    logic changed;                              // Flag for the tracer

    assign access_wr = (i_cmd == page_cmd_pkg::CMD_WRITE_ACCESS);

    // Fill has priority over the software write
    assign reprio_wr = (i_cmd == page_cmd_pkg::CMD_WRITE_REPRIO) && !port.fill_active;

    // ------------------------------
    // Used and dirty bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (access_wr) begin
            used_mem[port.pg_index]  <= i_data[1];
            dirty_mem[port.pg_index] <= i_data[2];
        end else if (port.req_strobe) begin
            used_mem[port.req_index] <= 1'b1;   // Any access marks it used
            if (port.req_dirty) begin
                dirty_mem[port.req_index] <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Reprioritize bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (port.fill_active) begin
            reprio_mem[port.fill_index] <= 1'b1;    // Hardware fill with ones
        end else if (reprio_wr) begin
            reprio_mem[port.pg_index] <= i_data[0];
        end
    end

    // Any write to a page table raises the flag until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            changed <= 1'b0;
        end else if (access_wr || reprio_wr || port.fill_active
                     || port.req_strobe || port.map_write) begin
            changed <= 1'b1;
        end
    end

    assign o_access  = {dirty_mem[port.pg_index], used_mem[port.pg_index], 1'b0};
    assign o_reprio  = reprio_mem[port.pg_index];
    assign o_changed = changed;

endmodule

`default_nettype wire

// ==== design/page_map.sv ====
// Map memory has no reset and reads asynchronously; BESM-6 mode only reaches map entries 0 to 31
`timescale 1ns/1ns
`default_nettype none

`include "page_unit_settings.svh"

module page_map (
    input  wire                     clk,            // Clock
    input  wire                     reset,          // Synchronous reset
    input  page_cmd_pkg::page_cmd_e i_cmd,          // Command this cycle
    input  wire  [`PU_VADDR_W-1:0]  i_data,         // Data word, same width as vaddr
    input  bus_op_pkg::arb_op_e     i_bus_op,       // Opcode of a bus request
    input  wire                     i_no_paging,    // Translation blocked
    input  wire                     i_mode_besm6,   // BESM-6 emulation mode
    output logic [`PU_PHYS_W-1:0]   o_physad,       // Translated address
    output logic [`PU_MAP_W-1:0]    o_map_data,     // Map entry at vaddr page
    attr_port_if.map_mp             port            // To the attribute memory
);

    logic [`PU_VADDR_W-1:0] vaddr;                  // Virtual address register
    logic [`PU_PAGE_W-1:0]  pg_index;               // Physical page register
    logic [`PU_MAP_W-1:0]   map_mem [`PU_PAGES];    // Page map
    logic [`PU_PAGE_W-1:0]  vaddr_page;             // Full-width page field
    logic [`PU_PAGE_W-1:0]  pg_virt;                // Mode-dependent virtual page
    logic [`PU_PAGE_W-1:0]  pg_translated;          // Result of translation

    assign vaddr_page = vaddr[`PU_OFFS_W +: `PU_PAGE_W];

    // ------------------------------
    // Translation
    // ------------------------------
    // BESM-6 keeps a 15-bit address, so only 5 page bits
    assign pg_virt = i_mode_besm6
        ? `PU_PAGE_W'(vaddr[`PU_OFFS_W +: `PU_BESM6_PAGE_W])
        : vaddr_page;

    assign pg_translated = i_no_paging
        ? pg_virt                                   // Identity when paging is off
        : map_mem[pg_virt][`PU_MAP_W-1 -: `PU_PAGE_W];

    assign o_physad   = {pg_translated, vaddr[`PU_OFFS_W-1:0]};
    assign o_map_data = map_mem[vaddr_page];        // Map read ignores the mode

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            vaddr    <= '0;
            pg_index <= '0;
        end else begin
            case (i_cmd)
                page_cmd_pkg::CMD_LOAD_VADDR:   vaddr    <= i_data;
                page_cmd_pkg::CMD_WRITE_PHYSPG: pg_index <= i_data[`PU_OFFS_W +: `PU_PAGE_W];
                page_cmd_pkg::CMD_BUS_REQUEST:  pg_index <= pg_translated;
                default: ;                          // Other commands leave them alone
            endcase
        end
    end

    // Map entry write at the unmodified vaddr page
    always_ff @(posedge clk) begin
        if (i_cmd == page_cmd_pkg::CMD_WRITE_MAP) begin
            map_mem[vaddr_page] <= i_data[`PU_MAP_W-1:0];
        end
    end

    // ------------------------------
    // Attribute port
    // ------------------------------
    assign port.pg_index   = pg_index;
    assign port.req_strobe = (i_cmd == page_cmd_pkg::CMD_BUS_REQUEST);
    assign port.req_index  = pg_translated;
    assign port.req_dirty  = bus_op_pkg::op_writes_memory(i_bus_op);
    assign port.map_write  = (i_cmd == page_cmd_pkg::CMD_WRITE_MAP);

endmodule

`default_nettype wire

// ==== design/fill_sequencer.sv ====
// A start command during a running fill is dropped; the fill always ends at the last page
`timescale 1ns/1ns
`default_nettype none

`include "page_unit_settings.svh"

module fill_sequencer (
    input  wire                     clk,            // Clock
    input  wire                     reset,          // Synchronous reset
    input  page_cmd_pkg::page_cmd_e i_cmd,          // Command this cycle
    input  wire  [`PU_PAGE_W-1:0]   i_start_index,  // Current page index
    input  wire  [`PU_PAGE_W-1:0]   i_count,        // Page from the counter
    input  wire                     i_count_last,   // Counter on the last page
    output logic                    o_load,         // Load the counter
    output logic                    o_step,         // Step the counter
    attr_port_if.fill_mp            port,           // Fill write port
    output logic                    o_fill_busy     // Fill in progress
);

    page_cmd_pkg::fill_state_e state;               // Current state
    page_cmd_pkg::fill_state_e state_nxt;           // Next state

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= page_cmd_pkg::FILL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------
    // Next state and counter control
    // ------------------------------
    always_comb begin
        state_nxt = state;
        o_load    = 1'b0;
        o_step    = 1'b0;
        case (state)
            page_cmd_pkg::FILL_IDLE: begin
                if (i_cmd == page_cmd_pkg::CMD_START_FILL) begin
                    o_load    = 1'b1;               // Counter takes the page index
                    state_nxt = page_cmd_pkg::FILL_RUN;
                end
            end
            page_cmd_pkg::FILL_RUN: begin
                if (i_count_last) begin
                    state_nxt = page_cmd_pkg::FILL_IDLE; // Last page written this edge
                end else begin
                    o_step = 1'b1;                  // Move to the next page
                end
            end
            default: state_nxt = page_cmd_pkg::FILL_IDLE;
        endcase
    end

    // Idle index shows where the next fill begins
    assign port.fill_active = (state == page_cmd_pkg::FILL_RUN);
    assign port.fill_index  = port.fill_active ? i_count : i_start_index;

    assign o_fill_busy = port.fill_active;

endmodule

`default_nettype wire

// ==== design/fill_counter.sv ====
// Counts upward only; stepping past the last page wraps, so the sequencer stops stepping there
`timescale 1ns/1ns
`default_nettype none

`include "page_unit_settings.svh"

module fill_counter (
    input  wire                   clk,      // Clock
    input  wire                   reset,    // Synchronous reset
    input  wire                   i_load,   // Take the start page
    input  wire  [`PU_PAGE_W-1:0] i_start,  // Start page
    input  wire                   i_step,   // Advance by one page
    output logic [`PU_PAGE_W-1:0] o_count,  // Page being walked
    output logic                  o_last    // Count sits on the last page
);

    logic [`PU_PAGE_W-1:0] count;           // Fill page counter

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (i_load) begin
            count <= i_start;               // Start of a new fill
        end else if (i_step) begin
            count <= count + 1'b1;          // One page per cycle
        end
    end

    assign o_count = count;

    // Last page is the top of the memory
    assign o_last = (count == `PU_PAGE_W'(`PU_PAGES - 1));

endmodule

`default_nettype wire

// ==== design/attr_port_if.sv ====
// Strobes on this bundle are combinational and act at the next clock edge in page_attr
`timescale 1ns/1ns
`default_nettype none

`include "page_unit_settings.svh"

interface attr_port_if;

    logic [`PU_PAGE_W-1:0] pg_index;    // Current physical page register
    logic                  req_strobe;  // Bus request this cycle
    logic [`PU_PAGE_W-1:0] req_index;   // Translated page of the request
    logic                  req_dirty;   // Request opcode writes memory
    logic                  map_write;   // Map entry written this cycle
    logic                  fill_active; // Fill owns the reprioritize memory
    logic [`PU_PAGE_W-1:0] fill_index;  // Page being filled

    // ------------------------------
    // Views
    // ------------------------------
    modport map_mp (
        output pg_index, req_strobe, req_index, req_dirty, map_write
    );

    modport fill_mp (
        output fill_active, fill_index
    );

    modport attr_mp (
        input pg_index, req_strobe, req_index, req_dirty, map_write,
        input fill_active, fill_index
    );

endinterface

`default_nettype wire

// ==== design/bus_op_pkg.sv ====
// Only the arbiter opcodes that matter to page marking are named; other codes act as reads
`default_nettype none

package bus_op_pkg;

    // ------------------------------
    // Arbiter opcodes
    // ------------------------------
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,             // No bus operation
        CCWR    = 4'd2,             // Instruction cache write
        DCWR    = 4'd4,             // Operand cache write
        DRD     = 4'd9,             // Data read
        DWR     = 4'd10,            // Result write
        RDMWR   = 4'd11,            // Read-modify-write
        BTRWR   = 4'd12             // Block transfer write
    } arb_op_e;

    // True when the operation stores into memory, which marks the page dirty
    function automatic logic op_writes_memory(input arb_op_e op);
        case (op)
            CCWR,
            DCWR,
            DWR,
            RDMWR,
            BTRWR:   return 1'b1;   // All write flavours
            default: return 1'b0;   // Reads and no-op
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== design/page_cmd_pkg.sv ====
// Command codes are single-cycle strobes with no handshake; only one command acts per cycle
`default_nettype none

package page_cmd_pkg;

    // ------------------------------
    // Per-cycle command code
    // ------------------------------
    // One code per cycle steers the whole page unit
    typedef enum logic [2:0] {
        CMD_NOP          = 3'd0,    // Nothing this cycle
        CMD_LOAD_VADDR   = 3'd1,    // Virtual address register from data
        CMD_WRITE_MAP    = 3'd2,    // Map entry at the current virtual page
        CMD_WRITE_PHYSPG = 3'd3,    // Physical page index from data bits 19:10
        CMD_WRITE_ACCESS = 3'd4,    // Used and dirty bits of the current page
        CMD_WRITE_REPRIO = 3'd5,    // Reprioritize bit of the current page
        CMD_START_FILL   = 3'd6,    // Fill reprioritize bits up to the last page
        CMD_BUS_REQUEST  = 3'd7     // Translate, load index, mark page used
    } page_cmd_e;

    // ------------------------------
    // Fill sequencer state
    // ------------------------------
    typedef enum logic {
        FILL_IDLE = 1'b0,           // Waiting for a start command
        FILL_RUN  = 1'b1            // Writing one page per cycle
    } fill_state_e;

endpackage

`default_nettype wire

// ==== design/page_unit_settings.svh ====
// Widths are fixed for the 1024-page map; page and offset must sum to the physical width
`ifndef PAGE_UNIT_SETTINGS_SVH
`define PAGE_UNIT_SETTINGS_SVH

// ------------------------------
// Address widths
// ------------------------------
`define PU_VADDR_W 32               // Virtual address register, also the data word
`define PU_PAGE_W 10                // Physical and virtual page index
`define PU_OFFS_W 10                // Offset inside a page
`define PU_PHYS_W 20                // Translated physical address

// ------------------------------
// Page map
// ------------------------------
`define PU_MAP_W 20                 // Map entry, page number in the top bits
`define PU_PAGES 1024               // Entries in every page memory

// BESM-6 emulation sees only 32 virtual pages
`define PU_BESM6_PAGE_W 5

`endif
